// File: sources.f
+incdir+src
src/regmux_pkg.sv
src/mux_tree.sv
src/mux_onehot.sv
src/apb_reg_if.sv
src/reg_bank.sv
src/regmux_top.sv
bench/tb_clock.sv
bench/regmux_tb.sv

// File: Bender.yml
package:
  name: regmux

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/regmux_pkg.sv
      - src/mux_tree.sv
      - src/mux_onehot.sv
      - src/apb_reg_if.sv
      - src/reg_bank.sv
      - src/regmux_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_clock.sv
      - bench/regmux_tb.sv

// File: bench/regmux_tb.sv
`default_nettype none

`include "regmux_defs.svh"

module regmux_tb;

    localparam int N = `REGMUX_NUM_REGS;

    // Access counts per test size the timeout
    localparam int RESET_ACCESSES  = 32;
    localparam int FILL_ACCESSES   = 48;
    localparam int LOCK_ACCESSES   = 12;
    localparam int ADDR_ACCESSES   = 15;
    localparam int LOOKUP_STEPS    = 26;
    localparam int BURST_ACCESSES  = 8;
    localparam int CYCLE_LIMIT     = 4 * (RESET_ACCESSES + FILL_ACCESSES + LOCK_ACCESSES
                                     + ADDR_ACCESSES + LOOKUP_STEPS + BURST_ACCESSES) + 100;

    logic                      clk;
    logic                      rst_n;
    logic [`REGMUX_ADDR_W-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    regmux_pkg::word_t         pwdata;
    logic                      pready;
    logic                      pslverr;
    regmux_pkg::word_t         prdata;
    regmux_pkg::onehot_t       lookup_sel;
    regmux_pkg::word_t         lookup_data;
    logic                      lookup_valid;

    // Reference model of the register file
    regmux_pkg::word_t model_words [N];
    logic              model_written [N];
    logic              model_locked [N];

    logic              exp_pready;
    logic              exp_pslverr;
    regmux_pkg::word_t exp_prdata;
    regmux_pkg::word_t exp_lookup_data;
    logic              exp_lookup_valid;

    integer              seed;
    int                  error_count = 0;
    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  errors_at_start = 0;
    int                  cycle_count = 0;
    regmux_pkg::onehot_t pick;
    logic [`REGMUX_ADDR_W-1:0] bad_addrs [6] = '{8'h01, 8'h02, 8'h43, 8'h80, 8'hC4, 8'hBC};

    tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

    regmux_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .prdata       (prdata),
        .lookup_sel   (lookup_sel),
        .lookup_data  (lookup_data),
        .lookup_valid (lookup_valid)
    );

    function automatic logic addr_valid(input logic [`REGMUX_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr[7] == 1'b0);
    endfunction

    function automatic logic expected_error(input logic [`REGMUX_ADDR_W-1:0] addr,
                                            input logic wr);
        int i;
        i = int'(addr[5:2]);
        if (!addr_valid(addr)) return 1'b1;
        // Flag space never refuses an aligned access
        if (addr[6]) return 1'b0;
        if (wr) return model_locked[i];
        return !model_written[i];
    endfunction

    function automatic regmux_pkg::word_t expected_read(input logic [`REGMUX_ADDR_W-1:0] addr);
        int i;
        i = int'(addr[5:2]);
        if (expected_error(addr, 1'b0)) return '0;
        if (addr[6]) return {30'b0, model_locked[i], model_written[i]};
        return model_words[i];
    endfunction

    function automatic logic [`REGMUX_ADDR_W-1:0] data_addr(input int idx);
        return {2'b00, regmux_pkg::reg_idx_t'(idx), 2'b00};
    endfunction

    function automatic logic [`REGMUX_ADDR_W-1:0] flag_addr(input int idx);
        return {2'b01, regmux_pkg::reg_idx_t'(idx), 2'b00};
    endfunction

    always_comb begin
        exp_pready  = psel && penable;
        exp_pslverr = 1'b0;
        exp_prdata  = '0;
        if (psel && penable) begin
            exp_pslverr = expected_error(paddr, pwrite);
            if (!pwrite) exp_prdata = expected_read(paddr);
        end
    end

    always_comb begin
        int ones;
        ones = 0;
        exp_lookup_data = '0;
        for (int i = 0; i < N; i++) begin
            if (lookup_sel[i]) begin
                exp_lookup_data = exp_lookup_data | model_words[i];
                ones++;
            end
        end
        exp_lookup_valid = (ones == 1);
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at time %0t: %s expected 0x%08h, got 0x%08h",
                 $time, name, expected, actual);
        error_count++;
    endtask

    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready == exp_pready)
        else report_mismatch("pready", $sampled(exp_pready), $sampled(pready));

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n) pslverr == exp_pslverr)
        else report_mismatch("pslverr", $sampled(exp_pslverr), $sampled(pslverr));

    a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
                               (psel && penable && !pwrite) |-> prdata == exp_prdata)
        else report_mismatch("prdata", $sampled(exp_prdata), $sampled(prdata));

    a_lookup_data: assert property (@(posedge clk) disable iff (!rst_n)
                                    lookup_data == exp_lookup_data)
        else report_mismatch("lookup_data", $sampled(exp_lookup_data), $sampled(lookup_data));

    a_lookup_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                     lookup_valid == exp_lookup_valid)
        else report_mismatch("lookup_valid", $sampled(exp_lookup_valid), $sampled(lookup_valid));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic apply_to_model(input logic wr, input logic [`REGMUX_ADDR_W-1:0] addr,
                                  input regmux_pkg::word_t data);
        int i;
        i = int'(addr[5:2]);
        if (wr && addr_valid(addr)) begin
            if (addr[6]) begin
                model_locked[i] = 1'b1;
            end else if (!model_locked[i]) begin
                model_words[i]   = data;
                model_written[i] = 1'b1;
            end
        end
    endtask

    // Setup phase then access phase with the bus left selected afterwards
    task automatic run_transfer(input logic wr, input logic [`REGMUX_ADDR_W-1:0] addr,
                                input regmux_pkg::word_t data);
        int waited;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!pready && waited < 8);
        if (!pready) begin
            $display("Transfer to address 0x%02h never got pready", addr);
            error_count++;
        end else begin
            apply_to_model(wr, addr, data);
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        @(posedge clk);
    endtask

    task automatic write_reg(input int idx, input regmux_pkg::word_t data);
        run_transfer(1'b1, data_addr(idx), data);
        go_idle();
    endtask

    task automatic read_reg(input int idx);
        run_transfer(1'b0, data_addr(idx), '0);
        go_idle();
    endtask

    task automatic lock_reg(input int idx);
        run_transfer(1'b1, flag_addr(idx), $random(seed));
        go_idle();
    endtask

    task automatic read_flags(input int idx);
        run_transfer(1'b0, flag_addr(idx), '0);
        go_idle();
    endtask

    task automatic set_lookup(input regmux_pkg::onehot_t sel);
        @(negedge clk);
        lookup_sel = sel;
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        // Let the checks of the last edge finish first
        @(negedge clk);
        if (error_count == errors_at_start) begin
            $display("Test %s: ok", name);
            pass_count++;
        end else begin
            $display("Test %s: FAIL with %0d errors", name, error_count - errors_at_start);
            fail_count++;
        end
        errors_at_start = error_count;
    endtask

    initial begin
        seed       = 37;
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        lookup_sel = '0;
        for (int i = 0; i < N; i++) begin
            model_words[i]   = '0;
            model_written[i] = 1'b0;
            model_locked[i]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N; i++) begin
            read_reg(i);
            read_flags(i);
        end
        end_test("reset_state");

        for (int i = 0; i < N; i++) write_reg(i, $random(seed));
        for (int i = 0; i < N; i++) read_reg(i);
        for (int i = 0; i < N; i++) read_flags(i);
        end_test("write_read");

        lock_reg(3);
        lock_reg(10);
        write_reg(3, $random(seed));
        write_reg(10, $random(seed));
        read_reg(3);
        read_reg(10);
        read_flags(3);
        read_flags(10);
        write_reg(4, $random(seed));
        write_reg(11, $random(seed));
        read_reg(4);
        read_reg(11);
        end_test("locking");

        foreach (bad_addrs[k]) begin
            run_transfer(1'b1, bad_addrs[k], $random(seed));
            go_idle();
            run_transfer(1'b0, bad_addrs[k], '0);
            go_idle();
        end
        // Entries that the bad addresses alias must be untouched
        read_reg(0);
        read_flags(0);
        read_flags(1);
        end_test("address_errors");

        for (int i = 0; i < N; i++) set_lookup(regmux_pkg::onehot_t'(1) << i);
        set_lookup('0);
        set_lookup('1);
        for (int k = 0; k < 8; k++) begin
            pick = $random(seed);
            if ($countones(pick) < 2) pick = pick | 16'h0101;
            set_lookup(pick);
        end
        end_test("lookup");

        for (int i = 5; i < 9; i++) begin
            run_transfer(1'b1, data_addr(i), $random(seed));
            run_transfer(1'b0, data_addr(i), '0);
        end
        go_idle();
        end_test("back_to_back");

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: src/regmux_top.sv
`default_nettype none

`include "regmux_defs.svh"

module regmux_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`REGMUX_ADDR_W-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  regmux_pkg::word_t         pwdata,
    output logic                      pready,
    output logic                      pslverr,
    output regmux_pkg::word_t         prdata,
    input  regmux_pkg::onehot_t       lookup_sel,
    output regmux_pkg::word_t         lookup_data,
    output logic                      lookup_valid
);

    logic                   wr_en;
    regmux_pkg::reg_idx_t   wr_idx;
    regmux_pkg::word_t      wr_data;
    logic                   lock_en;
    regmux_pkg::reg_idx_t   lock_idx;
    regmux_pkg::reg_idx_t   rd_idx;
    regmux_pkg::word_t      rd_word;
    regmux_pkg::reg_flags_t rd_flags;
    regmux_pkg::word_t      words [`REGMUX_NUM_REGS];
    regmux_pkg::reg_flags_t flags [`REGMUX_NUM_REGS];

    apb_reg_if u_apb (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .prdata   (prdata),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .lock_en  (lock_en),
        .lock_idx (lock_idx),
        .rd_idx   (rd_idx),
        .rd_word  (rd_word),
        .rd_flags (rd_flags)
    );

    reg_bank u_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .lock_en  (lock_en),
        .lock_idx (lock_idx),
        .words    (words),
        .flags    (flags)
    );

    // APB readback of the data word and its flags
    mux_tree #(
        .payload_t (regmux_pkg::word_t),
        .SEL_W     (`REGMUX_SEL_W)
    ) u_word_tree (
        .in  (words),
        .sel (rd_idx),
        .out (rd_word)
    );

    mux_tree #(
        .payload_t (regmux_pkg::reg_flags_t),
        .SEL_W     (`REGMUX_SEL_W)
    ) u_flag_tree (
        .in  (flags),
        .sel (rd_idx),
        .out (rd_flags)
    );

    mux_onehot #(
        .payload_t (regmux_pkg::word_t),
        .N         (`REGMUX_NUM_REGS)
    ) u_lookup (
        .in    (words),
        .sel   (lookup_sel),
        .out   (lookup_data),
        .valid (lookup_valid)
    );

endmodule

`default_nettype wire

// File: src/reg_bank.sv
`default_nettype none

`include "regmux_defs.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  regmux_pkg::reg_idx_t   wr_idx,
    input  regmux_pkg::word_t      wr_data,
    input  logic                   lock_en,
    input  regmux_pkg::reg_idx_t   lock_idx,
    output regmux_pkg::word_t      words [`REGMUX_NUM_REGS],
    output regmux_pkg::reg_flags_t flags [`REGMUX_NUM_REGS]
);

    // Storage is read out flat so every entry feeds the read multiplexers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REGMUX_NUM_REGS; i++) begin
                words[i] <= '0;
                flags[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                words[wr_idx]         <= wr_data;
                flags[wr_idx].written <= 1'b1;
            end
            if (lock_en) begin
                flags[lock_idx].locked <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/apb_reg_if.sv
`default_nettype none

`include "regmux_defs.svh"

module apb_reg_if (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REGMUX_ADDR_W-1:0]  paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  regmux_pkg::word_t          pwdata,
    output logic                       pready,
    output logic                       pslverr,
    output regmux_pkg::word_t          prdata,
    output logic                       wr_en,
    output regmux_pkg::reg_idx_t       wr_idx,
    output regmux_pkg::word_t          wr_data,
    output logic                       lock_en,
    output regmux_pkg::reg_idx_t       lock_idx,
    output regmux_pkg::reg_idx_t       rd_idx,
    input  regmux_pkg::word_t          rd_word,
    input  regmux_pkg::reg_flags_t     rd_flags
);

    logic                 setup_q;
    logic                 access;
    logic                 addr_ok;
    logic                 flag_space;
    logic                 rd_req;
    logic                 err;
    regmux_pkg::reg_idx_t idx;

    // Remember that the previous cycle was a setup phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel & ~penable;
        end
    end

    // Zero wait states: ready in every access that followed a setup
    assign pready = setup_q & psel & penable;
    assign access = pready;

    assign addr_ok    = (paddr[1:0] == 2'b00) && !paddr[7];
    assign flag_space = paddr[6];
    assign idx        = paddr[5:2];

    // The trees are steered by the address of the current transfer
    assign rd_idx = idx;

    assign wr_en    = access & pwrite & addr_ok & ~flag_space & ~rd_flags.locked;
    assign wr_idx   = idx;
    assign wr_data  = pwdata;
    assign lock_en  = access & pwrite & addr_ok & flag_space;
    assign lock_idx = idx;

    assign rd_req = access & ~pwrite & addr_ok;

    always_comb begin
        err = 1'b0;
        if (!addr_ok) begin
            err = 1'b1;
        end else if (!flag_space) begin
            // Locked entries refuse data writes, unwritten ones refuse reads
            err = pwrite ? rd_flags.locked : ~rd_flags.written;
        end
    end

    assign pslverr = access & err;

    always_comb begin
        prdata = '0;
        if (rd_req) begin
            if (flag_space) begin
                prdata = {{(`REGMUX_DATA_W-2){1'b0}}, rd_flags};
            end else if (rd_flags.written) begin
                prdata = rd_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/mux_onehot.sv
`default_nettype none

module mux_onehot #(
    parameter type payload_t = logic,
    parameter int  N         = 2
) (
    input  payload_t     in [N],
    input  logic [N-1:0] sel,
    output payload_t     out,
    output logic         valid
);

    // AND-OR stands in for a shared tri-state bus
    always_comb begin
        out = '0;
        for (int i = 0; i < N; i++) begin
            out = payload_t'(out | (in[i] & {$bits(payload_t){sel[i]}}));
        end
    end

    // Exactly one select bit set, otherwise the bus would float or fight
    assign valid = (sel != '0) && ((sel & (sel - 1'b1)) == '0);

endmodule

`default_nettype wire

// File: src/mux_tree.sv
`default_nettype none

module mux_tree #(
    parameter type payload_t = logic,
    parameter int  SEL_W     = 1
) (
    input  payload_t         in [2**SEL_W],
    input  logic [SEL_W-1:0] sel,
    output payload_t         out
);

    generate
        if (SEL_W == 1) begin : g_leaf
            assign out = sel[0] ? in[1] : in[0];
        end else begin : g_node
            payload_t layer [2**(SEL_W-1)];

            // Reduce adjacent pairs with the lowest select bit
            for (genvar i = 0; i < 2**(SEL_W-1); i++) begin : g_pair
                assign layer[i] = sel[0] ? in[2*i+1] : in[2*i];
            end

            // The remaining select bits pick among the halved set
            mux_tree #(
                .payload_t (payload_t),
                .SEL_W     (SEL_W-1)
            ) u_next (
                .in  (layer),
                .sel (sel[SEL_W-1:1]),
                .out (out)
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/regmux_pkg.sv
`default_nettype none

`include "regmux_defs.svh"

package regmux_pkg;

    // One register's data
    typedef logic [`REGMUX_DATA_W-1:0] word_t;

    // Binary register index
    typedef logic [`REGMUX_SEL_W-1:0] reg_idx_t;

    // Flag pair per entry, written sits in bit 0 and locked in bit 1
    typedef struct packed {
        logic locked;
        logic written;
    } reg_flags_t;

    // One select bit per register for the lookup port
    typedef logic [`REGMUX_NUM_REGS-1:0] onehot_t;

endpackage

`default_nettype wire

// File: src/regmux_defs.svh
`ifndef REGMUX_DEFS_SVH
`define REGMUX_DEFS_SVH

// Number of registers in the bank
`define REGMUX_NUM_REGS 16

// Width of a binary register index, log2 of the register count
`define REGMUX_SEL_W 4

// Width of one register word
`define REGMUX_DATA_W 32

// APB address width
`define REGMUX_ADDR_W 8

`endif
